//--- src/jtag_dbg_pkg.sv
// JTAG debug-side definitions: TAP states, instruction codes and scan register width
`default_nettype none

package jtag_dbg_pkg;

    // encoding follows the TAP state diagram walk order
    typedef enum logic [3:0] {
        test_logic_reset = 4'd0,
        run_test_idle    = 4'd1,
        select_dr_scan   = 4'd2,
        select_ir_scan   = 4'd3,
        capture_dr       = 4'd4,
        shift_dr         = 4'd5,
        exit1_dr         = 4'd6,
        pause_dr         = 4'd7,
        exit2_dr         = 4'd8,
        update_dr        = 4'd9,
        capture_ir       = 4'd10,
        shift_ir         = 4'd11,
        exit1_ir         = 4'd12,
        pause_ir         = 4'd13,
        exit2_ir         = 4'd14,
        update_ir        = 4'd15
    } tap_state_t;

    localparam int DR_W = 32;
    localparam logic [7:0] ID_VALUE = 8'h6a;

    // instruction register codes
    localparam logic [7:0] ir_id_code          = 8'h20;
    localparam logic [7:0] ir_reset_value      = 8'h02;
    localparam logic [7:0] ir_read_addr        = 8'h41;
    localparam logic [7:0] ir_read_mem         = 8'h42;
    localparam logic [7:0] ir_read_mem_incr    = 8'h43;
    localparam logic [7:0] ir_write_addr       = 8'h50;
    localparam logic [7:0] ir_write_mem16      = 8'h60;
    localparam logic [7:0] ir_write_mem16_incr = 8'h61;
    localparam logic [7:0] ir_write_mem32      = 8'h62;
    localparam logic [7:0] ir_write_mem32_incr = 8'h63;
    localparam logic [7:0] ir_write_mem8       = 8'h64;
    localparam logic [7:0] ir_write_mem8_incr  = 8'h65;
    localparam logic [7:0] ir_bypass           = 8'hff;

endpackage

`default_nettype wire

//--- src/apb_pkg.sv
// APB request and response bundles plus the transfer size type used by the debug master
`default_nettype none

package apb_pkg;

    typedef enum logic [1:0] {
        xfer_byte = 2'd0,
        xfer_half = 2'd1,
        xfer_word = 2'd2
    } xfer_size_t;

    // master to slave, 55 bits
    typedef struct packed {
        logic [15:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    // slave to master, 33 bits
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- src/jtag_tap_fsm.sv
// TAP controller, steps the 16-state JTAG sequence on TMS each rising edge
`timescale 1ns/10ps
`default_nettype none

module jtag_tap_fsm
    import jtag_dbg_pkg::*;
(
    input  wire        jtck_clock,
    input  wire        rst_n,
    input  wire        tms,
    output tap_state_t tap_state
);

    tap_state_t next_state;

    always_comb begin
        case (tap_state)
            test_logic_reset: next_state = tms ? test_logic_reset : run_test_idle;
            run_test_idle:    next_state = tms ? select_dr_scan : run_test_idle;
            select_dr_scan:   next_state = tms ? select_ir_scan : capture_dr;
            select_ir_scan:   next_state = tms ? test_logic_reset : capture_ir;
            capture_dr:       next_state = tms ? exit1_dr : shift_dr;
            shift_dr:         next_state = tms ? exit1_dr : shift_dr;
            exit1_dr:         next_state = tms ? update_dr : pause_dr;
            pause_dr:         next_state = tms ? exit2_dr : pause_dr;
            exit2_dr:         next_state = tms ? update_dr : shift_dr;
            update_dr:        next_state = tms ? select_dr_scan : run_test_idle;
            capture_ir:       next_state = tms ? exit1_ir : shift_ir;
            shift_ir:         next_state = tms ? exit1_ir : shift_ir;
            exit1_ir:         next_state = tms ? update_ir : pause_ir;
            pause_ir:         next_state = tms ? exit2_ir : pause_ir;
            exit2_ir:         next_state = tms ? update_ir : shift_ir;
            update_ir:        next_state = tms ? select_dr_scan : run_test_idle;
            default:          next_state = test_logic_reset;
        endcase
    end

    always_ff @(posedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            tap_state <= test_logic_reset;
        end else begin
            tap_state <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- src/jtag_scan_path.sv
// instruction and data scan registers with capture sources and the falling-edge TDO stage
`timescale 1ns/10ps
`default_nettype none

module jtag_scan_path
    import jtag_dbg_pkg::*;
(
    input  wire                  jtck_clock,
    input  wire                  rst_n,
    input  wire                  tdi,
    input  wire                  tms,
    input  wire tap_state_t      tap_state,
    input  wire [DR_W/2-1:0]     addr,
    input  wire [DR_W-1:0]       rd_word,
    output logic [7:0]           ir,
    output logic [DR_W-1:0]      dr_bits,
    output logic                 ir_update,
    output logic                 dr_update,
    output logic                 tdo
);

    logic [DR_W-1:0] sr;
    logic [DR_W-1:0] capture_value;

    always_comb begin
        case (ir)
            ir_id_code, ir_reset_value: capture_value = {{(DR_W-8){1'b0}}, ID_VALUE};
            ir_read_addr:               capture_value = {addr, addr};
            ir_read_mem,
            ir_read_mem_incr:           capture_value = rd_word;
            ir_bypass:                  capture_value = '0;
            // writes shift through whatever was left
            default:                    capture_value = sr;
        endcase
    end

    always_ff @(posedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            ir <= ir_reset_value;
            sr <= '0;
        end else begin
            case (tap_state)
                test_logic_reset: ir <= ir_reset_value;
                capture_ir:       sr <= {{(DR_W-8){1'b0}}, ir};
                shift_ir:         sr <= {tdi, sr[DR_W-1:1]};
                exit1_ir, exit2_ir: begin
                    // top byte holds the last 8 bits shifted in
                    if (tms) begin
                        ir <= sr[DR_W-1 -: 8];
                    end
                end
                capture_dr:       sr <= capture_value;
                shift_dr: begin
                    // bypass is a single-bit register
                    if (ir == ir_bypass) begin
                        sr[0] <= tdi;
                    end else begin
                        sr <= {tdi, sr[DR_W-1:1]};
                    end
                end
                default: ;
            endcase
        end
    end

    assign dr_bits = sr;

    // falling edge stage for TDO and update strobes
    always_ff @(negedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            tdo       <= 1'b0;
            ir_update <= 1'b0;
            dr_update <= 1'b0;
        end else begin
            tdo       <= sr[0];
            ir_update <= (tap_state == update_ir);
            dr_update <= (tap_state == update_dr);
        end
    end

endmodule

`default_nettype wire

//--- src/jtag_addr_counter.sv
// debug address register, loaded from a scan or stepped by the size of the last transfer
`timescale 1ns/10ps
`default_nettype none

module jtag_addr_counter
    import apb_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  wire               jtck_clock,
    input  wire               rst_n,
    input  wire               addr_load,
    input  wire [ADDR_W-1:0]  load_value,
    input  wire               addr_step,
    input  wire xfer_size_t   step_size,
    output logic [ADDR_W-1:0] addr
);

    logic [ADDR_W-1:0] step_amount;

    always_comb begin
        case (step_size)
            xfer_byte: step_amount = ADDR_W'(1);
            xfer_half: step_amount = ADDR_W'(2);
            default:   step_amount = ADDR_W'(4);
        endcase
    end

    // load wins over step
    always_ff @(posedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (addr_load) begin
            addr <= load_value;
        end else if (addr_step) begin
            addr <= addr + step_amount;
        end
    end

endmodule

`default_nettype wire

//--- src/jtag_apb_master.sv
// turns debug instructions and update strobes into single APB transfers and address steps
`timescale 1ns/10ps
`default_nettype none

module jtag_apb_master
    import jtag_dbg_pkg::*, apb_pkg::*;
#(
    parameter int ADDR_W = 16
) (
    input  wire               jtck_clock,
    input  wire               rst_n,
    input  wire [7:0]         ir,
    input  wire [DR_W-1:0]    dr_bits,
    input  wire               ir_update,
    input  wire               dr_update,
    input  wire [ADDR_W-1:0]  addr,
    output logic              addr_load,
    output logic [ADDR_W-1:0] load_value,
    output logic              addr_step,
    output xfer_size_t        step_size,
    output logic [DR_W-1:0]   rd_word,
    output apb_req_t          apb_req,
    input  wire apb_rsp_t     apb_rsp
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_setup,
        ph_access
    } phase_t;

    phase_t            phase;
    logic              is_write;
    logic              is_read;
    logic              is_incr;
    logic              start;
    xfer_size_t        dec_size;
    logic [31:0]       dec_wdata;
    logic [3:0]        dec_strb;
    logic              cur_incr;
    logic [ADDR_W-1:0] paddr_q;
    logic              pwrite_q;
    logic [31:0]       pwdata_q;
    logic [3:0]        pstrb_q;

    assign is_write = ir inside {ir_write_mem8, ir_write_mem8_incr, ir_write_mem16,
                                 ir_write_mem16_incr, ir_write_mem32, ir_write_mem32_incr};
    assign is_read  = ir inside {ir_read_mem, ir_read_mem_incr};
    assign is_incr  = ir inside {ir_write_mem8_incr, ir_write_mem16_incr,
                                 ir_write_mem32_incr, ir_read_mem_incr};

    // writes start on the DR update, reads on the IR update
    assign start = (phase == ph_idle) && ((dr_update && is_write) || (ir_update && is_read));

    always_comb begin
        case (ir)
            ir_write_mem8, ir_write_mem8_incr:   dec_size = xfer_byte;
            ir_write_mem16, ir_write_mem16_incr: dec_size = xfer_half;
            default:                             dec_size = xfer_word;
        endcase
    end

    // narrow data comes from the top of the scan, copied to every lane
    always_comb begin
        case (dec_size)
            xfer_byte: begin
                dec_wdata = {4{dr_bits[DR_W-1 -: 8]}};
                dec_strb  = 4'b0001 << addr[1:0];
            end
            xfer_half: begin
                dec_wdata = {2{dr_bits[DR_W-1 -: 16]}};
                dec_strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dec_wdata = dr_bits;
                dec_strb  = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ph_idle;
            addr_step <= 1'b0;
            rd_word   <= '0;
        end else begin
            addr_step <= 1'b0;
            case (phase)
                ph_idle: begin
                    if (start) begin
                        phase <= ph_setup;
                    end
                end
                ph_setup: phase <= ph_access;
                ph_access: begin
                    // hold until the slave is ready
                    if (apb_rsp.pready) begin
                        phase     <= ph_idle;
                        addr_step <= cur_incr;
                        if (!pwrite_q) begin
                            rd_word <= apb_rsp.prdata;
                        end
                    end
                end
                default: phase <= ph_idle;
            endcase
        end
    end

    always_ff @(posedge jtck_clock) begin
        if (start) begin
            paddr_q   <= addr;
            pwrite_q  <= is_write;
            pwdata_q  <= dec_wdata;
            pstrb_q   <= is_write ? dec_strb : 4'b0000;
            step_size <= dec_size;
            cur_incr  <= is_incr;
        end
    end

    always_comb begin
        apb_req.paddr   = paddr_q;
        apb_req.psel    = (phase != ph_idle);
        apb_req.penable = (phase == ph_access);
        apb_req.pwrite  = pwrite_q;
        apb_req.pwdata  = pwdata_q;
        apb_req.pstrb   = pstrb_q;
    end

    assign addr_load  = dr_update && (ir == ir_write_addr);
    assign load_value = dr_bits[DR_W-1 -: ADDR_W];

endmodule

`default_nettype wire

//--- src/debug_sram.sv
// small word memory on an APB slave port, byte lanes written by PSTRB, zero wait states
`timescale 1ns/10ps
`default_nettype none

module debug_sram
    import apb_pkg::*;
#(
    parameter int ADDR_W    = 16,
    parameter int MEM_WORDS = 64
) (
    input  wire            jtck_clock,
    input  wire            rst_n,
    input  wire apb_req_t  apb_req,
    output apb_rsp_t       apb_rsp
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;

    // word index wraps at the memory depth
    assign idx    = IDX_W'(apb_req.paddr[ADDR_W-1:2] % MEM_WORDS);
    assign access = apb_req.psel && apb_req.penable;

    assign apb_rsp.pready = access;
    assign apb_rsp.prdata = mem[idx];

    always_ff @(posedge jtck_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (access && apb_req.pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (apb_req.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apb_req.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/jtag_debug_top.sv
// top of the JTAG debug bridge, TAP and scan logic driving an APB master into on-chip memory
`timescale 1ns/10ps
`default_nettype none

module jtag_debug_top
    import jtag_dbg_pkg::*, apb_pkg::*;
#(
    parameter int ADDR_W    = 16,
    parameter int MEM_WORDS = 64
) (
    input  wire  jtck_clock,
    input  wire  rst_n,
    input  wire  tms,
    input  wire  tdi,
    output logic tdo
);

    tap_state_t        tap_state;
    logic [7:0]        ir;
    logic [DR_W-1:0]   dr_bits;
    logic [DR_W-1:0]   rd_word;
    logic              ir_update;
    logic              dr_update;
    logic [ADDR_W-1:0] addr;
    logic [ADDR_W-1:0] load_value;
    logic              addr_load;
    logic              addr_step;
    xfer_size_t        step_size;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;

    jtag_tap_fsm i_tap_fsm (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .tms        (tms),
        .tap_state  (tap_state)
    );

    jtag_scan_path i_scan_path (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .tdi        (tdi),
        .tms        (tms),
        .tap_state  (tap_state),
        .addr       (addr),
        .rd_word    (rd_word),
        .ir         (ir),
        .dr_bits    (dr_bits),
        .ir_update  (ir_update),
        .dr_update  (dr_update),
        .tdo        (tdo)
    );

    jtag_addr_counter #(.ADDR_W(ADDR_W)) i_addr_counter (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .addr_load  (addr_load),
        .load_value (load_value),
        .addr_step  (addr_step),
        .step_size  (step_size),
        .addr       (addr)
    );

    jtag_apb_master #(.ADDR_W(ADDR_W)) i_apb_master (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .ir         (ir),
        .dr_bits    (dr_bits),
        .ir_update  (ir_update),
        .dr_update  (dr_update),
        .addr       (addr),
        .addr_load  (addr_load),
        .load_value (load_value),
        .addr_step  (addr_step),
        .step_size  (step_size),
        .rd_word    (rd_word),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

    debug_sram #(.ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS)) i_debug_sram (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp)
    );

endmodule

`default_nettype wire

//--- verif/jtag_debug_checker.sv
// testbench scoreboard, samples TDO during scans and compares it with a memory and address model
`timescale 1ns/10ps
`default_nettype none

module jtag_debug_checker
    import apb_pkg::*;
#(
    parameter int ADDR_W    = 16,
    parameter int MEM_WORDS = 64
) (
    input wire jtck_clock,
    input wire tdo,
    input wire sample_en
);

    logic [7:0]        mem_model [MEM_WORDS*4];
    logic [ADDR_W-1:0] addr_model;
    logic [31:0]       observed;
    int                checks;
    int                errors;

    initial begin
        for (int i = 0; i < MEM_WORDS*4; i++) begin
            mem_model[i] = 8'h00;
        end
        addr_model = '0;
        checks     = 0;
        errors     = 0;
    end

    // lsb arrives first, older bits drop off the bottom
    always @(posedge jtck_clock) begin
        if (sample_en) begin
            observed <= {tdo, observed[31:1]};
        end
    end

    // memory wraps at MEM_WORDS words
    function automatic int byte_index(input logic [ADDR_W-1:0] a);
        return ((int'(a) >> 2) % MEM_WORDS) * 4 + int'(a[1:0]);
    endfunction

    function automatic logic [ADDR_W-1:0] size_bytes(input xfer_size_t size);
        case (size)
            xfer_byte: return ADDR_W'(1);
            xfer_half: return ADDR_W'(2);
            default:   return ADDR_W'(4);
        endcase
    endfunction

    task automatic load_addr(input logic [ADDR_W-1:0] value);
        addr_model = value;
    endtask

    task automatic model_write(input xfer_size_t size, input logic [31:0] data,
                               input logic incr);
        int base;
        base = byte_index(addr_model);
        case (size)
            xfer_byte: mem_model[base] = data[31:24];
            xfer_half: begin
                // halfword lanes follow address bit 1 only
                base = base & ~1;
                mem_model[base]     = data[23:16];
                mem_model[base + 1] = data[31:24];
            end
            default: begin
                base = base & ~3;
                for (int b = 0; b < 4; b++) begin
                    mem_model[base + b] = data[8*b +: 8];
                end
            end
        endcase
        if (incr) begin
            addr_model = addr_model + size_bytes(size);
        end
    endtask

    task automatic compare_scan(input string what, input logic [31:0] expected,
                                input int nbits);
        logic [31:0] got;
        got = observed >> (32 - nbits);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH time=%0t signal=tdo_word (%s) expected=%08h got=%08h",
                     $time, what, expected, got);
        end
    endtask

    task automatic expect_read(input logic incr);
        int base;
        base = byte_index(addr_model) & ~3;
        compare_scan("read word", {mem_model[base + 3], mem_model[base + 2],
                                   mem_model[base + 1], mem_model[base]}, 32);
        if (incr) begin
            addr_model = addr_model + ADDR_W'(4);
        end
    endtask

    task automatic expect_addr();
        compare_scan("address", {addr_model, addr_model}, 32);
    endtask

endmodule

`default_nettype wire

//--- verif/tb_jtag_debug.sv
// testbench for the JTAG debug bridge driving seeded random scan sequences through the TAP pins
`timescale 1ns/10ps
`default_nettype none

module tb_jtag_debug
    import jtag_dbg_pkg::*, apb_pkg::*;
();

    localparam int ADDR_W      = 16;
    localparam int MEM_WORDS   = 64;
    localparam int ADDR_TRIES  = 4;
    localparam int N_WORDS     = 8;
    localparam int N_NARROW    = 8;
    localparam int MAX_RUN     = 8;
    // worst case for one 32-bit scan with its idle gap
    localparam int SCAN_CYCLES = 44;
    localparam int TOTAL_SCANS = 4 + 4 * ADDR_TRIES + 8 * N_WORDS + 8 * N_NARROW
                               + 8 + 4 * MAX_RUN + 2;
    localparam int CYCLE_LIMIT = TOTAL_SCANS * SCAN_CYCLES * 3 / 2 + 32;

    logic jtck_clock;
    logic rst_n;
    logic tms;
    logic tdi;
    logic tdo;
    logic sample_en;
    int   cycles;
    int   errors_before;
    int   checks_before;
    int   test_num;

    jtag_debug_top #(.ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS)) i_jtag_debug_top (
        .jtck_clock (jtck_clock),
        .rst_n      (rst_n),
        .tms        (tms),
        .tdi        (tdi),
        .tdo        (tdo)
    );

    jtag_debug_checker #(.ADDR_W(ADDR_W), .MEM_WORDS(MEM_WORDS)) model_check (
        .jtck_clock (jtck_clock),
        .tdo        (tdo),
        .sample_en  (sample_en)
    );

    initial begin
        jtck_clock = 1'b0;
        forever #10 jtck_clock = ~jtck_clock;
    end

    initial begin
        cycles = 0;
    end

    always @(posedge jtck_clock) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge jtck_clock);
            tms <= 1'b0;
            tdi <= 1'b0;
        end
    endtask

    task automatic reset_tap();
        repeat (5) begin
            @(posedge jtck_clock);
            tms <= 1'b1;
        end
        idle(1);
    endtask

    // one scan from run_test_idle and back to it with the lsb first
    task automatic scan(input logic to_ir, input logic [31:0] bits, input int n);
        @(posedge jtck_clock);
        tms <= 1'b1;
        if (to_ir) begin
            @(posedge jtck_clock);
            tms <= 1'b1;
        end
        repeat (2) begin
            @(posedge jtck_clock);
            tms <= 1'b0;
        end
        for (int i = 0; i < n; i++) begin
            @(posedge jtck_clock);
            tdi       <= bits[i];
            tms       <= (i == n - 1);
            sample_en <= 1'b1;
        end
        @(posedge jtck_clock);
        tms       <= 1'b1;
        sample_en <= 1'b0;
        // four clocks in run_test_idle for the APB transfer
        idle(4);
    endtask

    task automatic shift_ir(input logic [7:0] code);
        scan(1'b1, {24'h0, code}, 8);
    endtask

    task automatic shift_dr(input logic [31:0] data, input int n);
        scan(1'b0, data, n);
    endtask

    task automatic set_addr(input logic [ADDR_W-1:0] a);
        shift_ir(ir_write_addr);
        shift_dr({a, {(32-ADDR_W){1'b0}}}, 32);
        model_check.load_addr(a);
    endtask

    task automatic write_mem(input xfer_size_t size, input logic incr, input logic [31:0] data);
        logic [7:0] code;
        case (size)
            xfer_byte: code = incr ? ir_write_mem8_incr : ir_write_mem8;
            xfer_half: code = incr ? ir_write_mem16_incr : ir_write_mem16;
            default:   code = incr ? ir_write_mem32_incr : ir_write_mem32;
        endcase
        shift_ir(code);
        shift_dr(data, 32);
        model_check.model_write(size, data, incr);
    endtask

    task automatic read_mem(input logic incr);
        shift_ir(incr ? ir_read_mem_incr : ir_read_mem);
        shift_dr(32'h0, 32);
        model_check.expect_read(incr);
    endtask

    task automatic read_addr();
        shift_ir(ir_read_addr);
        shift_dr(32'h0, 32);
        model_check.expect_addr();
    endtask

    task automatic id_code_after_reset();
        shift_dr($urandom, 32);
        model_check.compare_scan("id after reset", 32'h0000_006a, 32);
        shift_ir(ir_bypass);
        reset_tap();
        shift_dr($urandom, 32);
        model_check.compare_scan("id after tap reset", 32'h0000_006a, 32);
    endtask

    task automatic addr_roundtrip();
        for (int t = 0; t < ADDR_TRIES; t++) begin
            set_addr(16'($urandom));
            read_addr();
        end
    endtask

    task automatic word_write_readback();
        logic [15:0] addrs [N_WORDS];
        for (int w = 0; w < N_WORDS; w++) begin
            addrs[w] = 16'($urandom) & 16'hfffc;
            set_addr(addrs[w]);
            write_mem(xfer_word, 1'b0, $urandom);
        end
        for (int w = 0; w < N_WORDS; w++) begin
            set_addr(addrs[w]);
            read_mem(1'b0);
        end
    endtask

    task automatic narrow_lane_writes();
        xfer_size_t  size;
        logic [15:0] offset;
        for (int t = 0; t < N_NARROW; t++) begin
            size   = xfer_size_t'(2'($urandom % 2));
            offset = (size == xfer_byte) ? 16'($urandom % 4) : 16'(2 * ($urandom % 2));
            set_addr((16'($urandom) & 16'hfffc) + offset);
            write_mem(xfer_word, 1'b0, $urandom);
            write_mem(size, 1'b0, $urandom);
            read_mem(1'b0);
        end
    endtask

    task automatic incr_runs();
        logic [15:0] start;
        int          run_len;
        start   = 16'($urandom) & 16'hfffc;
        run_len = 4 + int'($urandom % (MAX_RUN - 3));
        set_addr(start);
        for (int t = 0; t < run_len; t++) begin
            write_mem(xfer_size_t'(2'($urandom % 3)), 1'b1, $urandom);
        end
        read_addr();
        set_addr(start);
        for (int t = 0; t < run_len; t++) begin
            read_mem(1'b1);
        end
        read_addr();
    endtask

    task automatic bypass_delay();
        logic [31:0] pattern;
        pattern = $urandom;
        shift_ir(ir_bypass);
        shift_dr(pattern, 24);
        // the single stage register puts out a zero first
        model_check.compare_scan("bypass", {pattern[30:0], 1'b0} & 32'h00ff_ffff, 24);
    endtask

    task automatic start_test();
        errors_before = model_check.errors;
        checks_before = model_check.checks;
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d checks, %0d errors", test_num, name,
                 model_check.checks - checks_before, model_check.errors - errors_before);
    endtask

    initial begin
        void'($urandom(30628));
        test_num  = 0;
        rst_n     <= 1'b0;
        tms       <= 1'b1;
        tdi       <= 1'b0;
        sample_en <= 1'b0;
        repeat (4) @(posedge jtck_clock);
        rst_n <= 1'b1;
        idle(2);

        start_test();
        id_code_after_reset();
        end_test("id_code");
        start_test();
        addr_roundtrip();
        end_test("addr_roundtrip");
        start_test();
        word_write_readback();
        end_test("word_rw");
        start_test();
        narrow_lane_writes();
        end_test("narrow_lanes");
        start_test();
        incr_runs();
        end_test("incr_runs");
        start_test();
        bypass_delay();
        end_test("bypass");

        $display("tests %0d, checks %0d, errors %0d", test_num, model_check.checks,
                 model_check.errors);
        if (model_check.errors == 0 && model_check.checks > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            if (model_check.checks == 0) begin
                $display("no scan results were compared");
            end
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/jtag_dbg_pkg.sv
src/apb_pkg.sv
src/jtag_tap_fsm.sv
src/jtag_scan_path.sv
src/jtag_addr_counter.sv
src/jtag_apb_master.sv
src/debug_sram.sv
src/jtag_debug_top.sv
verif/jtag_debug_checker.sv
verif/tb_jtag_debug.sv

//--- run_sim.sh
#!/bin/sh
# build the debug bridge testbench with Verilator, run it, then judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f filelist.f --top-module tb_jtag_debug -o tb_jtag_debug_sim
./obj_dir/tb_jtag_debug_sim | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation finished cleanly"
